/* logic/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// byte address as presented by the processor and carried on the ring
`define DC_ADDR_W 36

// address split is tag, then set index, then word select, then byte offset
`define DC_TAG_W 22
`define DC_TAG_LSB 14
`define DC_INDEX_W 8
`define DC_INDEX_LSB 6
`define DC_WORD_SEL_W 2
`define DC_WORD_SEL_LSB 4

// line geometry
`define DC_WORD_W 128
`define DC_WORDS_PER_LINE 4
`define DC_WAYS 2
// way select width, wide enough for DC_WAYS
`define DC_WAY_W 1
`define DC_SETS (1 << `DC_INDEX_W)

// ring slot fields
`define DC_ID_W 5
`define DC_PKT_W 3
`define DC_MASK_W 4

`endif

/* logic/dcache_core_pkg.sv */
package dcache_core_pkg;

  // store request type presented with every processor access
  typedef enum logic [1:0] {
    st_none   = 2'b00,
    st_lane32 = 2'b01,
    st_half36 = 2'b10,
    st_vector = 2'b11
  } store_kind_e;

  // miss handler states, the eviction steps come before the fill steps
  typedef enum logic [2:0] {
    ms_idle,
    ms_wb_read,
    ms_wb_send,
    ms_wb_ack,
    ms_fill_req,
    ms_fill_wait,
    ms_install
  } miss_state_e;

endpackage

/* logic/ring_pkg.sv */
`include "dcache_macros.svh"

package ring_pkg;

  // packet type held in a ring slot
  // the remaining codes belong to operations this node does not issue
  typedef enum logic [`DC_PKT_W-1:0] {
    pkt_empty    = 3'b000,
    pkt_write    = 3'b001,
    pkt_read_req = 3'b011,
    pkt_ack      = 3'b101,
    pkt_data     = 3'b110
  } ring_pkt_e;

endpackage

/* logic/data_cache_array.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module data_cache_array (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`DC_ADDR_W-1:0]     lookup_addr,
  output logic                      hit,
  output logic [`DC_WAY_W-1:0]      hit_way,
  output logic [`DC_WAY_W-1:0]      victim_way,
  output logic                      victim_dirty,
  output logic [`DC_TAG_W-1:0]      victim_tag,
  input  logic [`DC_INDEX_W-1:0]    rd_index,
  input  logic [`DC_WAY_W-1:0]      rd_way,
  input  logic [`DC_WORD_SEL_W-1:0] rd_word,
  output logic [`DC_WORD_W-1:0]     rd_data,
  input  logic                      st_wr_en,
  input  logic [`DC_INDEX_W-1:0]    st_wr_index,
  input  logic [`DC_WAY_W-1:0]      st_wr_way,
  input  logic [`DC_WORD_SEL_W-1:0] st_wr_word,
  input  logic [`DC_WORD_W-1:0]     st_wr_data,
  input  logic                      fill_wr_en,
  input  logic [`DC_INDEX_W-1:0]    fill_index,
  input  logic [`DC_WAY_W-1:0]      fill_way,
  input  logic [`DC_WORD_SEL_W-1:0] fill_word,
  input  logic [`DC_WORD_W-1:0]     fill_data,
  input  logic                      install_en,
  input  logic [`DC_TAG_W-1:0]      install_tag
);

  localparam int ENTRIES = `DC_SETS * `DC_WAYS * `DC_WORDS_PER_LINE;
  localparam int DADDR_W = `DC_INDEX_W + `DC_WAY_W + `DC_WORD_SEL_W;

  logic [`DC_TAG_W-1:0]             tag_mem [`DC_WAYS][`DC_SETS];
  logic [`DC_WORD_W-1:0]            data_mem [ENTRIES];
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid;
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty;
  logic [`DC_SETS-1:0]              repl;
  logic [`DC_INDEX_W-1:0]           lk_index;
  logic [`DC_TAG_W-1:0]             lk_tag;
  logic [`DC_WAYS-1:0]              way_hit;
  logic                             st_pending;
  logic                             wr_en;
  logic [DADDR_W-1:0]               wr_addr;
  logic [DADDR_W-1:0]               rd_addr;
  logic [`DC_WORD_W-1:0]            wr_data;

  assign lk_index = lookup_addr[`DC_INDEX_LSB +: `DC_INDEX_W];
  assign lk_tag   = lookup_addr[`DC_TAG_LSB +: `DC_TAG_W];

  always_comb begin
    way_hit = '0;
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      way_hit[w] = valid[w][lk_index] && (tag_mem[w][lk_index] == lk_tag);
      if (way_hit[w]) begin
        hit_way = w[`DC_WAY_W-1:0];
      end
    end
  end

  assign hit = |way_hit;

  // round-robin victim, the set's bit points at the way to replace next
  assign victim_way = repl[lk_index];
  assign victim_tag = tag_mem[victim_way][lk_index];

  // a store still waiting for its write edge already makes the victim dirty
  assign st_pending   = st_wr_en && (st_wr_index == lk_index) && (st_wr_way == victim_way);
  assign victim_dirty = valid[victim_way][lk_index] &&
                        (dirty[victim_way][lk_index] || st_pending);

  // one write port shared by store merges and arriving fill words
  assign wr_en   = st_wr_en || fill_wr_en;
  assign wr_addr = fill_wr_en ? {fill_index, fill_way, fill_word}
                              : {st_wr_index, st_wr_way, st_wr_word};
  assign wr_data = fill_wr_en ? fill_data : st_wr_data;
  assign rd_addr = {rd_index, rd_way, rd_word};

  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[wr_addr] <= wr_data;
    end
    rd_data <= data_mem[rd_addr];
  end

  always_ff @(posedge clk) begin
    if (install_en) begin
      tag_mem[fill_way][fill_index] <= install_tag;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid <= '0;
      dirty <= '0;
      repl  <= '0;
    end else begin
      if (st_wr_en) begin
        dirty[st_wr_way][st_wr_index] <= 1'b1;
      end
      // the installed line starts clean
      if (install_en) begin
        valid[fill_way][fill_index] <= 1'b1;
        dirty[fill_way][fill_index] <= 1'b0;
        repl[fill_index]            <= ~repl[fill_index];
      end
    end
  end

  // the store buffer and the miss handler never write in the same cycle
  assert property (@(posedge clk) disable iff (rst) !(st_wr_en && fill_wr_en))
    else $error("store write and fill write collide in the data array");

endmodule

/* logic/store_buffer.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module store_buffer
  import dcache_core_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`DC_ADDR_W-1:0]     addr,
  input  store_kind_e               st_kind,
  input  logic [`DC_MASK_W-1:0]     bit_mask,
  input  logic [`DC_WORD_W-1:0]     w_data,
  input  logic                      r,
  input  logic                      stall,
  input  logic [`DC_WAY_W-1:0]      hit_way,
  input  logic [`DC_WORD_W-1:0]     rd_data,
  output logic                      st_wr_en,
  output logic [`DC_INDEX_W-1:0]    st_wr_index,
  output logic [`DC_WAY_W-1:0]      st_wr_way,
  output logic [`DC_WORD_SEL_W-1:0] st_wr_word,
  output logic [`DC_WORD_W-1:0]     st_wr_data,
  output logic [`DC_WORD_W-1:0]     data_out
);

  logic                  st_accept;
  logic                  req_accept;
  logic                  same_word;
  logic                  sb_valid;
  logic                  fwd_q;
  store_kind_e           sb_kind;
  logic [`DC_ADDR_W-1:0] sb_addr;
  logic [`DC_WAY_W-1:0]  sb_way;
  logic [`DC_MASK_W-1:0] sb_mask;
  logic [`DC_WORD_W-1:0] sb_data;
  logic [`DC_WORD_W-1:0] last_word;
  logic [`DC_WORD_W-1:0] old_word;
  logic [`DC_WORD_W-1:0] merged;

  assign st_accept  = (st_kind != st_none) && !stall;
  assign req_accept = (r || (st_kind != st_none)) && !stall;

  // word granularity compare, the byte offset does not matter
  assign same_word = addr[`DC_ADDR_W-1:`DC_WORD_SEL_LSB] ==
                     sb_addr[`DC_ADDR_W-1:`DC_WORD_SEL_LSB];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      sb_valid <= 1'b0;
      fwd_q    <= 1'b0;
    end else begin
      sb_valid <= st_accept;
      // the array has not been written yet when the next access reads it
      fwd_q    <= req_accept && sb_valid && same_word;
    end
  end

  always_ff @(posedge clk) begin
    if (st_accept) begin
      sb_kind <= st_kind;
      sb_addr <= addr;
      sb_way  <= hit_way;
      sb_mask <= bit_mask;
      sb_data <= w_data;
    end
    if (sb_valid) begin
      last_word <= merged;
    end
  end

  assign old_word = fwd_q ? last_word : rd_data;
  assign data_out = old_word;

  always_comb begin
    merged = old_word;
    case (sb_kind)
      st_lane32: begin
        merged[{sb_addr[3:2], 5'd0} +: 32] = sb_data[31:0];
      end
      st_half36: begin
        // upper 28 bits of the chosen half are cleared
        merged[{sb_addr[3], 6'd0} +: 64] = {28'd0, sb_data[35:0]};
      end
      st_vector: begin
        // a set mask bit protects the old lane
        for (int l = 0; l < `DC_MASK_W; l++) begin
          if (!sb_mask[l]) begin
            merged[l*32 +: 32] = sb_data[l*32 +: 32];
          end
        end
      end
      default: begin
        merged = old_word;
      end
    endcase
  end

  assign st_wr_en    = sb_valid;
  assign st_wr_index = sb_addr[`DC_INDEX_LSB +: `DC_INDEX_W];
  assign st_wr_way   = sb_way;
  assign st_wr_word  = sb_addr[`DC_WORD_SEL_LSB +: `DC_WORD_SEL_W];
  assign st_wr_data  = merged;

endmodule

/* logic/miss_handler.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module miss_handler
  import dcache_core_pkg::*, ring_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      r,
  input  store_kind_e               st_kind,
  input  logic [`DC_ADDR_W-1:0]     addr,
  input  logic                      hit,
  input  logic [`DC_WAY_W-1:0]      hit_way,
  input  logic [`DC_WAY_W-1:0]      victim_way,
  input  logic                      victim_dirty,
  input  logic [`DC_TAG_W-1:0]      victim_tag,
  input  logic [`DC_WORD_W-1:0]     rd_data,
  input  logic [`DC_ID_W-1:0]       node_id,
  output logic                      stall,
  output logic [`DC_INDEX_W-1:0]    rd_index,
  output logic [`DC_WAY_W-1:0]      rd_way,
  output logic [`DC_WORD_SEL_W-1:0] rd_word,
  output logic                      fill_wr_en,
  output logic [`DC_INDEX_W-1:0]    fill_index,
  output logic [`DC_WAY_W-1:0]      fill_way,
  output logic [`DC_WORD_SEL_W-1:0] fill_word,
  output logic [`DC_WORD_W-1:0]     fill_data,
  output logic                      install_en,
  output logic [`DC_TAG_W-1:0]      install_tag,
  input  ring_pkt_e                 packet_type_req_in,
  input  logic [`DC_ID_W-1:0]       id_req_in,
  input  logic [`DC_ADDR_W-1:0]     mem_addr_in,
  input  logic [`DC_WORD_W-1:0]     mem_data_in,
  output logic                      overwrite,
  output ring_pkt_e                 packet_type_req_out,
  output logic [`DC_ADDR_W-1:0]     mem_addr_out,
  output logic [`DC_WORD_W-1:0]     mem_data_out
);

  miss_state_e               state;
  miss_state_e               next_state;
  logic [`DC_ADDR_W-1:0]     miss_addr;
  logic [`DC_WAY_W-1:0]      miss_way;
  logic [`DC_TAG_W-1:0]      evict_tag;
  logic [`DC_INDEX_W-1:0]    miss_index;
  logic [`DC_WORD_SEL_W-1:0] word_cnt;
  logic                      req;
  logic                      miss_start;
  logic                      cnt_inc;
  logic                      slot_free;
  logic                      own_ack;
  logic                      own_data;

  assign req        = r || (st_kind != st_none);
  assign miss_start = (state == ms_idle) && req && !hit;
  assign miss_index = miss_addr[`DC_INDEX_LSB +: `DC_INDEX_W];

  assign slot_free = packet_type_req_in == pkt_empty;
  assign own_ack   = (id_req_in == node_id) && (packet_type_req_in == pkt_ack);
  assign own_data  = (id_req_in == node_id) && (packet_type_req_in == pkt_data);

  always_comb begin
    next_state          = state;
    stall               = 1'b1;
    cnt_inc             = 1'b0;
    rd_index            = miss_index;
    rd_way              = miss_way;
    rd_word             = word_cnt;
    fill_wr_en          = 1'b0;
    install_en          = 1'b0;
    overwrite           = 1'b0;
    packet_type_req_out = pkt_empty;
    mem_addr_out        = {evict_tag, miss_index, word_cnt, {`DC_WORD_SEL_LSB{1'b0}}};
    case (state)
      ms_idle: begin
        // hits are served here while the read port tracks the processor
        stall    = miss_start;
        rd_index = addr[`DC_INDEX_LSB +: `DC_INDEX_W];
        rd_way   = hit_way;
        rd_word  = addr[`DC_WORD_SEL_LSB +: `DC_WORD_SEL_W];
        if (miss_start) begin
          next_state = victim_dirty ? ms_wb_read : ms_fill_req;
        end
      end
      ms_wb_read: begin
        next_state = ms_wb_send;
      end
      ms_wb_send: begin
        packet_type_req_out = pkt_write;
        if (slot_free) begin
          overwrite  = 1'b1;
          cnt_inc    = 1'b1;
          next_state = (word_cnt == '1) ? ms_wb_ack : ms_wb_read;
        end
      end
      ms_wb_ack: begin
        // releasing the slot consumes the ack
        if (own_ack) begin
          overwrite  = 1'b1;
          next_state = ms_fill_req;
        end
      end
      ms_fill_req: begin
        packet_type_req_out = pkt_read_req;
        mem_addr_out        = {miss_addr[`DC_ADDR_W-1:`DC_INDEX_LSB], {`DC_INDEX_LSB{1'b0}}};
        if (slot_free) begin
          overwrite  = 1'b1;
          next_state = ms_fill_wait;
        end
      end
      ms_fill_wait: begin
        if (own_data) begin
          overwrite  = 1'b1;
          fill_wr_en = 1'b1;
          cnt_inc    = 1'b1;
          if (word_cnt == '1) begin
            next_state = ms_install;
          end
        end
      end
      ms_install: begin
        install_en = 1'b1;
        next_state = ms_idle;
      end
      default: begin
        next_state = ms_idle;
      end
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state    <= ms_idle;
      word_cnt <= '0;
    end else begin
      state <= next_state;
      if (miss_start) begin
        word_cnt <= '0;
      end else if (cnt_inc) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // the victim is fixed for the whole miss
  always_ff @(posedge clk) begin
    if (miss_start) begin
      miss_addr <= addr;
      miss_way  <= victim_way;
      evict_tag <= victim_tag;
    end
  end

  assign mem_data_out = rd_data;
  assign fill_index   = miss_index;
  assign fill_way     = miss_way;
  assign fill_word    = mem_addr_in[`DC_WORD_SEL_LSB +: `DC_WORD_SEL_W];
  assign fill_data    = mem_data_in;
  assign install_tag  = miss_addr[`DC_TAG_LSB +: `DC_TAG_W];

  // a response for this node is taken off the ring in the cycle it arrives
  assert property (@(posedge clk) disable iff (rst)
    (own_ack || own_data) |-> overwrite)
    else $error("response for this node left in the slot without being consumed");

endmodule

/* logic/dcache_ctrl_top.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_ctrl_top
  import dcache_core_pkg::*, ring_pkg::*;
#(
  parameter logic [`DC_ID_W-1:0] NODE_ID = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  r,
  input  store_kind_e           st_kind,
  input  logic [`DC_MASK_W-1:0] bit_mask,
  input  logic [`DC_ADDR_W-1:0] addr,
  input  logic [`DC_WORD_W-1:0] w_data,
  input  ring_pkt_e             packet_type_req_in,
  input  logic [`DC_ID_W-1:0]   id_req_in,
  input  logic [`DC_ADDR_W-1:0] mem_addr_in,
  input  logic [`DC_WORD_W-1:0] mem_data_in,
  output logic [`DC_WORD_W-1:0] data_out,
  output logic                  stall,
  output logic                  overwrite,
  output ring_pkt_e             packet_type_req_out,
  output logic [`DC_ADDR_W-1:0] mem_addr_out,
  output logic [`DC_WORD_W-1:0] mem_data_out,
  output logic [`DC_ID_W-1:0]   id_req_out
);

  logic                      hit;
  logic [`DC_WAY_W-1:0]      hit_way;
  logic [`DC_WAY_W-1:0]      victim_way;
  logic                      victim_dirty;
  logic [`DC_TAG_W-1:0]      victim_tag;
  logic [`DC_INDEX_W-1:0]    rd_index;
  logic [`DC_WAY_W-1:0]      rd_way;
  logic [`DC_WORD_SEL_W-1:0] rd_word;
  logic [`DC_WORD_W-1:0]     rd_data;
  logic                      st_wr_en;
  logic [`DC_INDEX_W-1:0]    st_wr_index;
  logic [`DC_WAY_W-1:0]      st_wr_way;
  logic [`DC_WORD_SEL_W-1:0] st_wr_word;
  logic [`DC_WORD_W-1:0]     st_wr_data;
  logic                      fill_wr_en;
  logic [`DC_INDEX_W-1:0]    fill_index;
  logic [`DC_WAY_W-1:0]      fill_way;
  logic [`DC_WORD_SEL_W-1:0] fill_word;
  logic [`DC_WORD_W-1:0]     fill_data;
  logic                      install_en;
  logic [`DC_TAG_W-1:0]      install_tag;

  // every packet this node puts on the ring carries its own id
  assign id_req_out = NODE_ID;

  data_cache_array data_cache_array_inst (
    .clk(clk), .rst(rst), .lookup_addr(addr),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
    .victim_dirty(victim_dirty), .victim_tag(victim_tag),
    .rd_index(rd_index), .rd_way(rd_way), .rd_word(rd_word), .rd_data(rd_data),
    .st_wr_en(st_wr_en), .st_wr_index(st_wr_index), .st_wr_way(st_wr_way),
    .st_wr_word(st_wr_word), .st_wr_data(st_wr_data),
    .fill_wr_en(fill_wr_en), .fill_index(fill_index), .fill_way(fill_way),
    .fill_word(fill_word), .fill_data(fill_data),
    .install_en(install_en), .install_tag(install_tag)
  );

  store_buffer store_buffer_inst (
    .clk(clk), .rst(rst), .addr(addr), .st_kind(st_kind), .bit_mask(bit_mask),
    .w_data(w_data), .r(r), .stall(stall), .hit_way(hit_way), .rd_data(rd_data),
    .st_wr_en(st_wr_en), .st_wr_index(st_wr_index), .st_wr_way(st_wr_way),
    .st_wr_word(st_wr_word), .st_wr_data(st_wr_data), .data_out(data_out)
  );

  miss_handler miss_handler_inst (
    .clk(clk), .rst(rst), .r(r), .st_kind(st_kind), .addr(addr),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
    .victim_dirty(victim_dirty), .victim_tag(victim_tag),
    .rd_data(rd_data), .node_id(id_req_out), .stall(stall),
    .rd_index(rd_index), .rd_way(rd_way), .rd_word(rd_word),
    .fill_wr_en(fill_wr_en), .fill_index(fill_index), .fill_way(fill_way),
    .fill_word(fill_word), .fill_data(fill_data),
    .install_en(install_en), .install_tag(install_tag),
    .packet_type_req_in(packet_type_req_in), .id_req_in(id_req_in),
    .mem_addr_in(mem_addr_in), .mem_data_in(mem_data_in),
    .overwrite(overwrite), .packet_type_req_out(packet_type_req_out),
    .mem_addr_out(mem_addr_out), .mem_data_out(mem_data_out)
  );

endmodule

/* verif/ring_memory_model.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module ring_memory_model
  import ring_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  foreign_en,
  input  logic                  overwrite,
  input  ring_pkt_e             pkt_out,
  input  logic [`DC_ID_W-1:0]   id_out,
  input  logic [`DC_ADDR_W-1:0] addr_out,
  input  logic [`DC_WORD_W-1:0] data_out,
  output ring_pkt_e             pkt_in,
  output logic [`DC_ID_W-1:0]   id_in,
  output logic [`DC_ADDR_W-1:0] addr_in,
  output logic [`DC_WORD_W-1:0] data_in,
  output int                    write_count
);

  localparam logic [`DC_ID_W-1:0] FOREIGN_ID = 5'd9;

  // backing memory indexed by word address, untouched words read their pattern
  logic [`DC_WORD_W-1:0] mem [logic [31:0]];
  ring_pkt_e             rsp_type_q [$];
  logic [`DC_ID_W-1:0]   rsp_id_q [$];
  logic [`DC_ADDR_W-1:0] rsp_addr_q [$];
  logic [`DC_WORD_W-1:0] rsp_data_q [$];
  logic [`DC_ADDR_W-1:0] word_addr;

  function automatic logic [`DC_WORD_W-1:0] mem_word(logic [31:0] wa);
    if (mem.exists(wa)) begin
      return mem[wa];
    end
    return {4{wa}};
  endfunction

  always @(posedge clk, posedge rst) begin
    if (rst) begin
      pkt_in      <= pkt_empty;
      id_in       <= '0;
      addr_in     <= '0;
      data_in     <= '0;
      write_count <= 0;
    end else if (overwrite) begin
      // the node's packet leaves the slot at once, so the slot is free again
      pkt_in <= pkt_empty;
      id_in  <= '0;
      case (pkt_out)
        pkt_write: begin
          mem[addr_out[`DC_ADDR_W-1:4]] = data_out;
          write_count <= write_count + 1;
          // a whole line has arrived after every fourth write
          if (write_count % 4 == 3) begin
            rsp_type_q.push_back(pkt_ack);
            rsp_id_q.push_back(id_out);
            rsp_addr_q.push_back(addr_out);
            rsp_data_q.push_back('0);
          end
        end
        pkt_read_req: begin
          for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
            word_addr = {addr_out[`DC_ADDR_W-1:6], w[1:0], 4'd0};
            rsp_type_q.push_back(pkt_data);
            rsp_id_q.push_back(id_out);
            rsp_addr_q.push_back(word_addr);
            rsp_data_q.push_back(mem_word(word_addr[`DC_ADDR_W-1:4]));
          end
        end
        default: begin
        end
      endcase
    end else if (pkt_in != pkt_empty && id_in == FOREIGN_ID) begin
      // traffic of other nodes moves on after one cycle
      pkt_in <= pkt_empty;
      id_in  <= '0;
    end else if (pkt_in == pkt_empty) begin
      if (foreign_en && ($urandom % 4 == 0)) begin
        pkt_in  <= pkt_data;
        id_in   <= FOREIGN_ID;
        addr_in <= {$urandom, 4'd0};
        data_in <= {$urandom, $urandom, $urandom, $urandom};
      end else if (rsp_type_q.size() > 0) begin
        pkt_in  <= rsp_type_q.pop_front();
        id_in   <= rsp_id_q.pop_front();
        addr_in <= rsp_addr_q.pop_front();
        data_in <= rsp_data_q.pop_front();
      end
    end
  end

endmodule

/* verif/dcache_ctrl_tb.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_ctrl_tb
  import dcache_core_pkg::*, ring_pkg::*;
();

  localparam int NUM_TESTS    = 6;
  localparam int ACCEPT_LIMIT = 1000;
  localparam logic [`DC_ID_W-1:0] NODE_ID = 5'd3;

  logic                  clk;
  logic                  rst;
  logic                  r;
  store_kind_e           st_kind;
  logic [`DC_MASK_W-1:0] bit_mask;
  logic [`DC_ADDR_W-1:0] addr;
  logic [`DC_WORD_W-1:0] w_data;
  ring_pkt_e             pkt_in;
  logic [`DC_ID_W-1:0]   id_in;
  logic [`DC_ADDR_W-1:0] mem_addr_in;
  logic [`DC_WORD_W-1:0] mem_data_in;
  logic [`DC_WORD_W-1:0] data_out;
  logic                  stall;
  logic                  overwrite;
  ring_pkt_e             pkt_out;
  logic [`DC_ADDR_W-1:0] mem_addr_out;
  logic [`DC_WORD_W-1:0] mem_data_out;
  logic [`DC_ID_W-1:0]   id_out;
  logic                  foreign_en;
  int                    write_count;
  int                    errors;
  int                    tests_run;
  int                    ow_count;
  logic [`DC_WORD_W-1:0] shadow [logic [31:0]];
  logic [`DC_ADDR_W-1:0] wr_addr_q [$];
  logic [`DC_WORD_W-1:0] wr_data_q [$];

  dcache_ctrl_top #(.NODE_ID(NODE_ID)) dcache_ctrl_top_inst (
    .clk(clk), .rst(rst), .r(r), .st_kind(st_kind), .bit_mask(bit_mask),
    .addr(addr), .w_data(w_data), .packet_type_req_in(pkt_in), .id_req_in(id_in),
    .mem_addr_in(mem_addr_in), .mem_data_in(mem_data_in), .data_out(data_out),
    .stall(stall), .overwrite(overwrite), .packet_type_req_out(pkt_out),
    .mem_addr_out(mem_addr_out), .mem_data_out(mem_data_out), .id_req_out(id_out)
  );

  ring_memory_model ring_memory_model_inst (
    .clk(clk), .rst(rst), .foreign_en(foreign_en), .overwrite(overwrite),
    .pkt_out(pkt_out), .id_out(id_out), .addr_out(mem_addr_out),
    .data_out(mem_data_out), .pkt_in(pkt_in), .id_in(id_in),
    .addr_in(mem_addr_in), .data_in(mem_data_in), .write_count(write_count)
  );

  always #5 clk = ~clk;

  // every write packet the controller puts on the ring as seen at the DUT ports
  always @(posedge clk) begin
    if (overwrite) begin
      ow_count <= ow_count + 1;
    end
    if (overwrite && pkt_out == pkt_write) begin
      wr_addr_q.push_back(mem_addr_out);
      wr_data_q.push_back(mem_data_out);
    end
  end

  initial begin
    #(NUM_TESTS * 2000 * 10);
    $display("Watchdog expired, the run did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic logic [`DC_ADDR_W-1:0] make_addr(int tag, int index, int word);
    return {tag[21:0], index[7:0], word[1:0], 4'd0};
  endfunction

  function automatic logic [`DC_WORD_W-1:0] shadow_word(logic [31:0] wa);
    if (shadow.exists(wa)) begin
      return shadow[wa];
    end
    return {4{wa}};
  endfunction

  function automatic logic [`DC_WORD_W-1:0] apply_store(logic [`DC_WORD_W-1:0] old,
      store_kind_e kind, logic [`DC_ADDR_W-1:0] a, logic [3:0] mask,
      logic [`DC_WORD_W-1:0] wd);
    logic [`DC_WORD_W-1:0] res;
    int                    lane;
    int                    half;
    res  = old;
    lane = int'(a[3:2]);
    half = int'(a[3]);
    case (kind)
      st_lane32: res[lane*32 +: 32] = wd[31:0];
      st_half36: res[half*64 +: 64] = {28'd0, wd[35:0]};
      st_vector: begin
        for (int l = 0; l < 4; l++) begin
          if (!mask[l]) begin
            res[l*32 +: 32] = wd[l*32 +: 32];
          end
        end
      end
      default: res = old;
    endcase
    return res;
  endfunction

  function automatic logic [`DC_WORD_W-1:0] rand_word();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic check_value(input logic [`DC_WORD_W-1:0] actual,
      input logic [`DC_WORD_W-1:0] expected, input string msg);
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  // waits at falling edges until the request is no longer stalled
  task automatic wait_accept(output int stall_cycles);
    stall_cycles = 0;
    @(negedge clk);
    while (stall && stall_cycles < ACCEPT_LIMIT) begin
      stall_cycles++;
      @(negedge clk);
    end
    if (stall) begin
      errors++;
      $display("Request at address %h was never accepted, stall stayed high", addr);
    end
  endtask

  task automatic access(input logic rd, input store_kind_e kind, input logic [3:0] mask,
      input logic [`DC_ADDR_W-1:0] a, input logic [`DC_WORD_W-1:0] wd,
      output logic [`DC_WORD_W-1:0] rdata, output int stall_cycles);
    @(posedge clk);
    r        <= rd;
    st_kind  <= kind;
    bit_mask <= mask;
    addr     <= a;
    w_data   <= wd;
    wait_accept(stall_cycles);
    @(posedge clk);
    r       <= 1'b0;
    st_kind <= st_none;
    @(negedge clk);
    rdata = data_out;
  endtask

  task automatic store_word(input store_kind_e kind, input logic [`DC_ADDR_W-1:0] a,
      input logic [3:0] mask, input logic [`DC_WORD_W-1:0] wd);
    logic [`DC_WORD_W-1:0] unused;
    int                    cycles;
    access(1'b0, kind, mask, a, wd, unused, cycles);
    shadow[a[35:4]] = apply_store(shadow_word(a[35:4]), kind, a, mask, wd);
  endtask

  task automatic read_check(input logic [`DC_ADDR_W-1:0] a, input string msg,
      output int cycles);
    logic [`DC_WORD_W-1:0] rdata;
    access(1'b1, st_none, 4'd0, a, '0, rdata, cycles);
    check_value(rdata, shadow_word(a[35:4]), msg);
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    $display("test %s finished with %0d errors", name, errors - start_errors);
  endtask

  task automatic after_reset_outputs();
    int e0;
    e0 = errors;
    @(negedge clk);
    check_value(stall, 1'b0, "stall high after reset");
    check_value(overwrite, 1'b0, "overwrite high after reset");
    check_value(pkt_out, pkt_empty, "packet type not empty after reset");
    check_value(id_out, NODE_ID, "ring id differs from the node id");
    finish_test("reset_state", e0);
  endtask

  task automatic cold_line_read(input int index);
    int e0;
    int cycles;
    int ow0;
    e0 = errors;
    read_check(make_addr(5, index, 2), "cold read data", cycles);
    check_value(cycles > 0, 1'b1, "cold read did not stall");
    ow0 = ow_count;
    read_check(make_addr(5, index, 2), "repeated read data", cycles);
    check_value(cycles, 0, "repeated read stalled");
    check_value(ow_count - ow0, 0, "repeated read used the ring");
    finish_test("cold_read", e0);
  endtask

  task automatic store_kind_merges(input int index);
    logic [`DC_ADDR_W-1:0] a;
    int                    e0;
    int                    cycles;
    e0 = errors;
    a  = make_addr(7, index, 1);
    for (int lane = 0; lane < 4; lane++) begin
      store_word(st_lane32, a | (lane << 2), 4'd0, rand_word());
      read_check(a, "lane32 store merge", cycles);
    end
    for (int h = 0; h < 2; h++) begin
      store_word(st_half36, a | (h << 3), 4'd0, rand_word());
      read_check(a, "half36 store merge", cycles);
    end
    for (int k = 0; k < 4; k++) begin
      store_word(st_vector, a, 4'($urandom), rand_word());
      read_check(a, "vector store merge", cycles);
    end
    finish_test("store_kinds", e0);
  endtask

  task automatic store_then_read(input int index);
    logic [`DC_ADDR_W-1:0] a;
    logic [`DC_WORD_W-1:0] wd;
    int                    e0;
    int                    cycles;
    e0 = errors;
    a  = make_addr(9, index, 3);
    // bring the line in first so both accesses hit
    read_check(a, "forward setup read", cycles);
    wd = rand_word();
    @(posedge clk);
    r        <= 1'b0;
    st_kind  <= st_lane32;
    addr     <= a | 36'h4;
    w_data   <= wd;
    wait_accept(cycles);
    @(posedge clk);
    shadow[a[35:4]] = apply_store(shadow_word(a[35:4]), st_lane32, a | 36'h4, 4'd0, wd);
    r       <= 1'b1;
    st_kind <= st_none;
    @(negedge clk);
    check_value(stall, 1'b0, "read after store stalled");
    @(posedge clk);
    r <= 1'b0;
    @(negedge clk);
    check_value(data_out, shadow_word(a[35:4]), "read right after store");
    finish_test("store_forward", e0);
  endtask

  task automatic dirty_line_eviction(input int index);
    logic [`DC_ADDR_W-1:0] a;
    logic [`DC_ADDR_W-1:0] wa;
    int                    e0;
    int                    cycles;
    int                    n0;
    int                    wc0;
    e0 = errors;
    a  = make_addr(1, index, 1);
    store_word(st_lane32, a, 4'd0, rand_word());
    read_check(make_addr(2, index, 0), "second line read", cycles);
    n0  = wr_addr_q.size();
    wc0 = write_count;
    // the third line pushes out the dirty first line
    read_check(make_addr(3, index, 0), "third line read", cycles);
    check_value(wr_addr_q.size() - n0, 4, "write packets seen at the DUT");
    check_value(write_count - wc0, 4, "write packets counted by the memory");
    for (int i = n0; i < n0 + 4 && i < wr_addr_q.size(); i++) begin
      wa = make_addr(1, index, i - n0);
      check_value(wr_addr_q[i], wa, "evicted word address");
      check_value(wr_data_q[i], shadow_word(wa[35:4]), "evicted word data");
    end
    read_check(a, "evicted line read back", cycles);
    finish_test("eviction", e0);
  endtask

  task automatic foreign_traffic_rerun();
    int e0;
    e0 = errors;
    @(posedge clk);
    foreign_en <= 1'b1;
    cold_line_read(20);
    store_kind_merges(21);
    store_then_read(22);
    dirty_line_eviction(23);
    @(posedge clk);
    foreign_en <= 1'b0;
    tests_run -= 4;
    finish_test("ring_traffic", e0);
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    r          = 1'b0;
    st_kind    = st_none;
    bit_mask   = '0;
    addr       = '0;
    w_data     = '0;
    foreign_en = 1'b0;
    errors     = 0;
    tests_run  = 0;
    ow_count   = 0;
    void'($urandom(36));
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    after_reset_outputs();
    cold_line_read(1);
    store_kind_merges(2);
    store_then_read(3);
    dirty_line_eviction(4);
    foreign_traffic_rerun();
    $display("tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* dcache_ctrl_top.f */
+incdir+logic
logic/dcache_core_pkg.sv
logic/ring_pkg.sv
logic/data_cache_array.sv
logic/store_buffer.sv
logic/miss_handler.sv
logic/dcache_ctrl_top.sv
verif/ring_memory_model.sv
verif/dcache_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cache controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f dcache_ctrl_top.f \
  --top-module dcache_ctrl_tb -o dcache_sim > build.log 2>&1 &&
./obj_dir/dcache_sim > sim.log 2>&1 ||
{ echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
